// ==== filelist.f ====
+incdir+logic
logic/alu_pkg.sv
logic/alu_req_arbiter.sv
logic/alu_shifter.sv
logic/alu_adder.sv
logic/alu_result_sel.sv
logic/alu_shared_buf.sv
logic/alu_dpath.sv
verif/alu_dpath_props.sv
verif/alu_dpath_tb.sv

// ==== logic/alu_adder.sv ====
`include "alu_defs.svh"

module alu_adder (
  input  alu_pkg::alu_op_e        op,
  input  logic [`ALU_XLEN-1:0]    op1,
  input  logic [`ALU_XLEN-1:0]    op2,
  output logic [`ALU_ADDER_W-1:0] sum
);

  import alu_pkg::*;

  logic                    op_unsigned;
  logic                    op_sub;
  logic                    op_addsub;
  logic [`ALU_ADDER_W-1:0] ext_op1;
  logic [`ALU_ADDER_W-1:0] ext_op2;
  logic [`ALU_ADDER_W-1:0] adder_in1;
  logic [`ALU_ADDER_W-1:0] adder_in2;
  logic [`ALU_ADDER_W-1:0] adder_cin;

  // Zero extension for the unsigned relations
  assign op_unsigned = op inside {OP_SLTU, OP_CMP_LTU, OP_CMP_GEU, OP_MAXU, OP_MINU};

  // EQ and NE are settled by the xor, not here
  assign op_sub = op inside {OP_SUB, OP_SLT, OP_SLTU, OP_MAX, OP_MIN, OP_MAXU, OP_MINU,
                             OP_CMP_LT, OP_CMP_GE, OP_CMP_LTU, OP_CMP_GEU};
  assign op_addsub = op_sub | (op == OP_ADD);

  assign ext_op1 = {{(`ALU_ADDER_W-`ALU_XLEN){~op_unsigned & op1[`ALU_XLEN-1]}}, op1};
  assign ext_op2 = {{(`ALU_ADDER_W-`ALU_XLEN){~op_unsigned & op2[`ALU_XLEN-1]}}, op2};

  // Inputs held at zero when no adder op is in flight
  assign adder_in1 = {`ALU_ADDER_W{op_addsub}} & ext_op1;
  assign adder_in2 = {`ALU_ADDER_W{op_addsub}} & (op_sub ? ~ext_op2 : ext_op2);
  // Two's complement carry in
  assign adder_cin = {{(`ALU_ADDER_W-1){1'b0}}, op_sub};

  assign sum = adder_in1 + adder_in2 + adder_cin;

endmodule

// ==== logic/alu_defs.svh ====
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

// Data word
`define ALU_XLEN 32

// Adder carries one extra sign bit for compares
`define ALU_ADDER_W 33

// Shift amount, op2 bits 4..0
`define ALU_SHAMT_W 5

`endif

// ==== logic/alu_dpath.sv ====
`include "alu_defs.svh"

module alu_dpath (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 alu_req,
  input  logic                 bjp_req,
  input  logic                 agu_req,
  input  logic [`ALU_XLEN-1:0] alu_op1,
  input  logic [`ALU_XLEN-1:0] alu_op2,
  input  logic [`ALU_XLEN-1:0] bjp_op1,
  input  logic [`ALU_XLEN-1:0] bjp_op2,
  input  logic [`ALU_XLEN-1:0] agu_op1,
  input  logic [`ALU_XLEN-1:0] agu_op2,
  input  logic                 alu_add, alu_sub, alu_xor, alu_sll,
  input  logic                 alu_srl, alu_sra, alu_or, alu_and,
  input  logic                 alu_slt, alu_sltu, alu_lui,
  input  logic                 bjp_add, bjp_cmp_eq, bjp_cmp_ne, bjp_cmp_lt,
  input  logic                 bjp_cmp_ge, bjp_cmp_ltu, bjp_cmp_geu,
  input  logic                 agu_add, agu_and, agu_or, agu_xor, agu_swap,
  input  logic                 agu_max, agu_min, agu_maxu, agu_minu,
  input  logic                 agu_sbf_0_ena,
  input  logic [`ALU_XLEN-1:0] agu_sbf_0_nxt,
  input  logic                 agu_sbf_1_ena,
  input  logic [`ALU_XLEN-1:0] agu_sbf_1_nxt,
  output logic                 alu_gnt,
  output logic                 bjp_gnt,
  output logic                 agu_gnt,
  output logic [`ALU_XLEN-1:0] res,
  output logic                 cmp_res,
  output logic [`ALU_XLEN-1:0] agu_sbf_0_r,
  output logic [`ALU_XLEN-1:0] agu_sbf_1_r
);

  import alu_pkg::*;

  // Winner's opcode and operands, shared by all units
  alu_op_e                 op;
  logic [`ALU_XLEN-1:0]    op1;
  logic [`ALU_XLEN-1:0]    op2;
  logic [`ALU_ADDER_W-1:0] sum;
  logic [`ALU_XLEN-1:0]    shift_res;

  ////////////////////////////////////////////////////////////
  // Request mux
  ////////////////////////////////////////////////////////////
  alu_req_arbiter u_arbiter (.*);

  ////////////////////////////////////////////////////////////
  // Compute units
  ////////////////////////////////////////////////////////////
  alu_shifter u_shifter (.*);

  alu_adder u_adder (.*);

  alu_result_sel u_result_sel (.*);

  // AGU scratch buffers, written regardless of grant
  alu_shared_buf u_shared_buf (.*);

endmodule

// ==== logic/alu_pkg.sv ====
package alu_pkg;

  // Shared opcode seen by every unit of the datapath
  typedef enum logic [4:0] {
    OP_NONE,
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_OR,
    OP_AND,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_SLT,
    OP_SLTU,
    OP_MVOP2,
    OP_MAX,
    OP_MIN,
    OP_MAXU,
    OP_MINU,
    OP_CMP_EQ,
    OP_CMP_NE,
    OP_CMP_LT,
    OP_CMP_GE,
    OP_CMP_LTU,
    OP_CMP_GEU
  } alu_op_e;

  // Requestor that owns the datapath this cycle
  typedef enum logic [1:0] {REQ_NONE, REQ_ALU, REQ_BJP, REQ_AGU} alu_req_e;

endpackage

// ==== logic/alu_req_arbiter.sv ====
`include "alu_defs.svh"

module alu_req_arbiter (
  input  logic                 alu_req,
  input  logic                 bjp_req,
  input  logic                 agu_req,
  input  logic [`ALU_XLEN-1:0] alu_op1,
  input  logic [`ALU_XLEN-1:0] alu_op2,
  input  logic [`ALU_XLEN-1:0] bjp_op1,
  input  logic [`ALU_XLEN-1:0] bjp_op2,
  input  logic [`ALU_XLEN-1:0] agu_op1,
  input  logic [`ALU_XLEN-1:0] agu_op2,
  // Regular ALU flags
  input  logic                 alu_add, alu_sub, alu_xor, alu_sll,
  input  logic                 alu_srl, alu_sra, alu_or, alu_and,
  input  logic                 alu_slt, alu_sltu, alu_lui,
  // Branch unit flags
  input  logic                 bjp_add, bjp_cmp_eq, bjp_cmp_ne, bjp_cmp_lt,
  input  logic                 bjp_cmp_ge, bjp_cmp_ltu, bjp_cmp_geu,
  // Address unit flags
  input  logic                 agu_add, agu_and, agu_or, agu_xor, agu_swap,
  input  logic                 agu_max, agu_min, agu_maxu, agu_minu,
  output logic                 alu_gnt,
  output logic                 bjp_gnt,
  output logic                 agu_gnt,
  output alu_pkg::alu_op_e     op,
  output logic [`ALU_XLEN-1:0] op1,
  output logic [`ALU_XLEN-1:0] op2
);

  import alu_pkg::*;

  alu_req_e winner;

  ////////////////////////////////////////////////////////////
  // Fixed priority, ALU over BJP over AGU
  ////////////////////////////////////////////////////////////
  always_comb begin
    if (alu_req) begin
      winner = REQ_ALU;
    end else if (bjp_req) begin
      winner = REQ_BJP;
    end else if (agu_req) begin
      winner = REQ_AGU;
    end else begin
      winner = REQ_NONE;
    end
  end

  assign alu_gnt = (winner == REQ_ALU);
  assign bjp_gnt = (winner == REQ_BJP);
  assign agu_gnt = (winner == REQ_AGU);

  ////////////////////////////////////////////////////////////
  // Flag encoding, earliest opcode wins on multiple flags
  ////////////////////////////////////////////////////////////
  always_comb begin
    // Idle datapath sees zeros
    op  = OP_NONE;
    op1 = '0;
    op2 = '0;
    case (winner)
      REQ_ALU: begin
        op1 = alu_op1;
        op2 = alu_op2;
        if (alu_add) op = OP_ADD;
        else if (alu_sub) op = OP_SUB;
        else if (alu_xor) op = OP_XOR;
        else if (alu_or) op = OP_OR;
        else if (alu_and) op = OP_AND;
        else if (alu_sll) op = OP_SLL;
        else if (alu_srl) op = OP_SRL;
        else if (alu_sra) op = OP_SRA;
        else if (alu_slt) op = OP_SLT;
        else if (alu_sltu) op = OP_SLTU;
        // LUI is a plain move of the immediate
        else if (alu_lui) op = OP_MVOP2;
      end
      REQ_BJP: begin
        op1 = bjp_op1;
        op2 = bjp_op2;
        if (bjp_add) op = OP_ADD;
        else if (bjp_cmp_eq) op = OP_CMP_EQ;
        else if (bjp_cmp_ne) op = OP_CMP_NE;
        else if (bjp_cmp_lt) op = OP_CMP_LT;
        else if (bjp_cmp_ge) op = OP_CMP_GE;
        else if (bjp_cmp_ltu) op = OP_CMP_LTU;
        else if (bjp_cmp_geu) op = OP_CMP_GEU;
      end
      REQ_AGU: begin
        op1 = agu_op1;
        op2 = agu_op2;
        if (agu_add) op = OP_ADD;
        else if (agu_xor) op = OP_XOR;
        else if (agu_or) op = OP_OR;
        else if (agu_and) op = OP_AND;
        // Swap returns op2 as the value to store
        else if (agu_swap) op = OP_MVOP2;
        else if (agu_max) op = OP_MAX;
        else if (agu_min) op = OP_MIN;
        else if (agu_maxu) op = OP_MAXU;
        else if (agu_minu) op = OP_MINU;
      end
      default: begin
        op = OP_NONE;
      end
    endcase
  end

endmodule

// ==== logic/alu_result_sel.sv ====
`include "alu_defs.svh"

module alu_result_sel (
  input  alu_pkg::alu_op_e        op,
  input  logic [`ALU_XLEN-1:0]    op1,
  input  logic [`ALU_XLEN-1:0]    op2,
  input  logic [`ALU_ADDER_W-1:0] sum,
  input  logic [`ALU_XLEN-1:0]    shift_res,
  output logic [`ALU_XLEN-1:0]    res,
  output logic                    cmp_res
);

  import alu_pkg::*;

  logic [`ALU_XLEN-1:0] xor_res;
  logic [`ALU_XLEN-1:0] or_res;
  logic [`ALU_XLEN-1:0] and_res;
  logic                 neq;
  logic                 lt;
  logic [`ALU_XLEN-1:0] slt_res;
  logic                 sel_op1;
  logic [`ALU_XLEN-1:0] maxmin_res;

  ////////////////////////////////////////////////////////////
  // Bitwise units
  ////////////////////////////////////////////////////////////
  assign xor_res = op1 ^ op2;
  assign or_res  = op1 | op2;
  assign and_res = op1 & op2;

  ////////////////////////////////////////////////////////////
  // Relations
  ////////////////////////////////////////////////////////////
  // Any differing bit means not equal
  assign neq = |xor_res;
  // Negative difference, sign bit of the wide sum
  assign lt  = sum[`ALU_XLEN];

  always_comb begin
    case (op)
      OP_CMP_EQ:  cmp_res = ~neq;
      OP_CMP_NE:  cmp_res = neq;
      OP_CMP_LT:  cmp_res = lt;
      OP_CMP_GE:  cmp_res = ~lt;
      OP_CMP_LTU: cmp_res = lt;
      OP_CMP_GEU: cmp_res = ~lt;
      default:    cmp_res = 1'b0;
    endcase
  end

  assign slt_res = {{(`ALU_XLEN-1){1'b0}}, lt};

  // Max keeps op1 when not less, min keeps it when less
  assign sel_op1    = (op inside {OP_MAX, OP_MAXU}) ? ~lt : lt;
  assign maxmin_res = sel_op1 ? op1 : op2;

  ////////////////////////////////////////////////////////////
  // Final result
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (op)
      OP_ADD, OP_SUB:                   res = sum[`ALU_XLEN-1:0];
      OP_XOR:                           res = xor_res;
      OP_OR:                            res = or_res;
      OP_AND:                           res = and_res;
      OP_SLL, OP_SRL, OP_SRA:           res = shift_res;
      OP_SLT, OP_SLTU:                  res = slt_res;
      OP_MVOP2:                         res = op2;
      OP_MAX, OP_MIN, OP_MAXU, OP_MINU: res = maxmin_res;
      // Compares only drive cmp_res
      default:                          res = '0;
    endcase
  end

endmodule

// ==== logic/alu_shared_buf.sv ====
`include "alu_defs.svh"

module alu_shared_buf (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 agu_sbf_0_ena,
  input  logic [`ALU_XLEN-1:0] agu_sbf_0_nxt,
  input  logic                 agu_sbf_1_ena,
  input  logic [`ALU_XLEN-1:0] agu_sbf_1_nxt,
  output logic [`ALU_XLEN-1:0] agu_sbf_0_r,
  output logic [`ALU_XLEN-1:0] agu_sbf_1_r
);

  logic [1:0]                ena;
  logic [1:0][`ALU_XLEN-1:0] nxt;
  logic [1:0][`ALU_XLEN-1:0] buf_q;

  assign ena = {agu_sbf_1_ena, agu_sbf_0_ena};
  assign nxt = {agu_sbf_1_nxt, agu_sbf_0_nxt};

  // Scratch words kept across the steps of an AGU sequence
  always_ff @(posedge clk) begin
    if (rst) begin
      buf_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (ena[i]) buf_q[i] <= nxt[i];
      end
    end
  end

  assign agu_sbf_0_r = buf_q[0];
  assign agu_sbf_1_r = buf_q[1];

endmodule

// ==== logic/alu_shifter.sv ====
`include "alu_defs.svh"

module alu_shifter (
  input  alu_pkg::alu_op_e     op,
  input  logic [`ALU_XLEN-1:0] op1,
  input  logic [`ALU_XLEN-1:0] op2,
  output logic [`ALU_XLEN-1:0] shift_res
);

  import alu_pkg::*;

  logic                    op_shift;
  logic                    op_right;
  logic [`ALU_SHAMT_W-1:0] shamt;
  logic [`ALU_XLEN-1:0]    shift_in;
  logic [`ALU_XLEN-1:0]    left_res;
  logic [`ALU_XLEN-1:0]    srl_res;
  logic [`ALU_XLEN-1:0]    sra_res;
  logic [`ALU_XLEN-1:0]    eff_mask;

  // Mirror a word end to end
  function automatic logic [`ALU_XLEN-1:0] bit_rev(input logic [`ALU_XLEN-1:0] d);
    logic [`ALU_XLEN-1:0] r;
    for (int i = 0; i < `ALU_XLEN; i++) begin
      r[i] = d[`ALU_XLEN-1-i];
    end
    return r;
  endfunction

  assign op_shift = op inside {OP_SLL, OP_SRL, OP_SRA};
  assign op_right = op inside {OP_SRL, OP_SRA};

  // Right shifts go through the one left shifter on a mirrored word
  assign shift_in = op_shift ? (op_right ? bit_rev(op1) : op1) : '0;
  assign shamt    = op_shift ? op2[`ALU_SHAMT_W-1:0] : '0;
  assign left_res = shift_in << shamt;
  assign srl_res  = bit_rev(left_res);

  // Ones where the logical result kept data
  assign eff_mask = {`ALU_XLEN{1'b1}} >> shamt;
  assign sra_res  = (srl_res & eff_mask) | ({`ALU_XLEN{op1[`ALU_XLEN-1]}} & ~eff_mask);

  always_comb begin
    case (op)
      OP_SLL:  shift_res = left_res;
      OP_SRL:  shift_res = srl_res;
      OP_SRA:  shift_res = sra_res;
      default: shift_res = '0;
    endcase
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only if the pass message shows up
verilator --binary --assert -f filelist.f --top-module alu_dpath_tb \
  && ./obj_dir/Valu_dpath_tb | tee /dev/stderr | grep -qF '=== PASS ===' \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

// ==== verif/alu_dpath_props.sv ====
`include "alu_defs.svh"

module alu_dpath_props (
  input logic                 clk,
  input logic                 rst,
  input logic                 alu_req,
  input logic                 bjp_req,
  input logic                 agu_req,
  input logic                 alu_gnt,
  input logic                 bjp_gnt,
  input logic                 agu_gnt,
  input logic [`ALU_XLEN-1:0] agu_sbf_0_r,
  input logic [`ALU_XLEN-1:0] agu_sbf_1_r
);

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////////////////////////
  // Grants
  ////////////////////////////////////////////////////////////
  // At most one owner of the datapath
  grant_onehot: assert property (@(posedge clk) $onehot0({alu_gnt, bjp_gnt, agu_gnt}))
    else $error("more than one grant high");

  // No grant without its request
  alu_gnt_req: assert property (@(posedge clk) alu_gnt |-> alu_req)
    else $error("alu_gnt without alu_req");
  bjp_gnt_req: assert property (@(posedge clk) bjp_gnt |-> bjp_req)
    else $error("bjp_gnt without bjp_req");
  agu_gnt_req: assert property (@(posedge clk) agu_gnt |-> agu_req)
    else $error("agu_gnt without agu_req");

  // Top priority never waits
  alu_req_gnt: assert property (@(posedge clk) alu_req |-> alu_gnt)
    else $error("alu_req not granted");

  ////////////////////////////////////////////////////////////
  // Shared buffers
  ////////////////////////////////////////////////////////////
  buf_reset: assert property (@(posedge clk) rst |=> (agu_sbf_0_r == '0 && agu_sbf_1_r == '0))
    else $error("shared buffers not cleared by reset");

endmodule

bind alu_dpath alu_dpath_props u_props (
  .clk(clk), .rst(rst), .alu_req(alu_req), .bjp_req(bjp_req), .agu_req(agu_req),
  .alu_gnt(alu_gnt), .bjp_gnt(bjp_gnt), .agu_gnt(agu_gnt),
  .agu_sbf_0_r(agu_sbf_0_r), .agu_sbf_1_r(agu_sbf_1_r)
);

// ==== verif/alu_dpath_tb.sv ====
`include "alu_defs.svh"

module alu_dpath_tb;

  timeunit 1ns;
  timeprecision 1ps;

  // Flag bit positions in fl with one block per requestor
  localparam int A_ADD = 0, A_SUB = 1, A_XOR = 2, A_SLL = 3, A_SRL = 4, A_SRA = 5,
                 A_OR = 6, A_AND = 7, A_SLT = 8, A_SLTU = 9, A_LUI = 10;
  localparam int B_ADD = 11, B_EQ = 12, B_NE = 13, B_LT = 14, B_GE = 15, B_LTU = 16,
                 B_GEU = 17;
  localparam int G_ADD = 18, G_AND = 19, G_OR = 20, G_XOR = 21, G_SWAP = 22,
                 G_MAX = 23, G_MIN = 24, G_MAXU = 25, G_MINU = 26;
  // Request bits {agu, bjp, alu} and the grants share this layout
  localparam logic [2:0] R_ALU = 3'b001, R_BJP = 3'b010, R_AGU = 3'b100;
  // Mixed-sign pair where the negative word is lower only when signed
  localparam logic [31:0] NEG = 32'hffff_fff0, POS = 32'h0000_0005;
  localparam int N_RAND = 200;

  typedef struct packed {
    logic [2:0]           req;
    logic [26:0]          fl;
    logic [`ALU_XLEN-1:0] a;
    logic [`ALU_XLEN-1:0] b;
    logic [`ALU_XLEN-1:0] res;
    logic                 cmp;
    logic [2:0]           gnt;
  } row_t;

  logic                      clk;
  logic                      rst;
  logic [2:0]                req;
  logic [26:0]               fl;
  // Operand pairs per requestor in the {agu, bjp, alu} order
  logic [2:0][`ALU_XLEN-1:0] op_a;
  logic [2:0][`ALU_XLEN-1:0] op_b;
  logic [1:0]                sbf_ena;
  logic [`ALU_XLEN-1:0]      sbf_nxt0;
  logic [`ALU_XLEN-1:0]      sbf_nxt1;
  logic [2:0]                gnt;
  logic [`ALU_XLEN-1:0]      res;
  logic                      cmp_res;
  logic [`ALU_XLEN-1:0]      sbf_r0;
  logic [`ALU_XLEN-1:0]      sbf_r1;

  row_t rows[$];
  int   passes = 0;
  int   fails = 0;
  int   limit = 0;

  alu_dpath uut (
    .clk, .rst, .alu_req(req[0]), .bjp_req(req[1]), .agu_req(req[2]),
    .alu_op1(op_a[0]), .alu_op2(op_b[0]), .bjp_op1(op_a[1]), .bjp_op2(op_b[1]),
    .agu_op1(op_a[2]), .agu_op2(op_b[2]),
    .alu_add(fl[0]), .alu_sub(fl[1]), .alu_xor(fl[2]), .alu_sll(fl[3]),
    .alu_srl(fl[4]), .alu_sra(fl[5]), .alu_or(fl[6]), .alu_and(fl[7]),
    .alu_slt(fl[8]), .alu_sltu(fl[9]), .alu_lui(fl[10]),
    .bjp_add(fl[11]), .bjp_cmp_eq(fl[12]), .bjp_cmp_ne(fl[13]), .bjp_cmp_lt(fl[14]),
    .bjp_cmp_ge(fl[15]), .bjp_cmp_ltu(fl[16]), .bjp_cmp_geu(fl[17]),
    .agu_add(fl[18]), .agu_and(fl[19]), .agu_or(fl[20]), .agu_xor(fl[21]),
    .agu_swap(fl[22]), .agu_max(fl[23]), .agu_min(fl[24]), .agu_maxu(fl[25]),
    .agu_minu(fl[26]),
    .agu_sbf_0_ena(sbf_ena[0]), .agu_sbf_0_nxt(sbf_nxt0),
    .agu_sbf_1_ena(sbf_ena[1]), .agu_sbf_1_nxt(sbf_nxt1),
    .alu_gnt(gnt[0]), .bjp_gnt(gnt[1]), .agu_gnt(gnt[2]), .res, .cmp_res,
    .agu_sbf_0_r(sbf_r0), .agu_sbf_1_r(sbf_r1)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference model returning {grants, cmp_res, res}
  ////////////////////////////////////////////////////////////
  function automatic logic [35:0] predict(input logic [2:0] rq, input logic [26:0] f,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [2:0]         g;
    logic               c;
    logic [31:0]        r;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic [4:0]         sh;
    sa = a;
    sb = b;
    sh = b[4:0];
    c = 1'b0;
    r = '0;
    // ALU first, then BJP, then AGU
    g = rq[0] ? R_ALU : rq[1] ? R_BJP : rq[2] ? R_AGU : 3'b000;
    // Flags tested in opcode order
    if (g[0]) begin
      if (f[A_ADD]) r = a + b;
      else if (f[A_SUB]) r = a - b;
      else if (f[A_XOR]) r = a ^ b;
      else if (f[A_OR]) r = a | b;
      else if (f[A_AND]) r = a & b;
      else if (f[A_SLL]) r = a << sh;
      else if (f[A_SRL]) r = a >> sh;
      else if (f[A_SRA]) r = sa >>> sh;
      else if (f[A_SLT]) r = {31'b0, sa < sb};
      else if (f[A_SLTU]) r = {31'b0, a < b};
      else if (f[A_LUI]) r = b;
    end else if (g[1]) begin
      if (f[B_ADD]) r = a + b;
      else if (f[B_EQ]) c = (a == b);
      else if (f[B_NE]) c = (a != b);
      else if (f[B_LT]) c = (sa < sb);
      else if (f[B_GE]) c = (sa >= sb);
      else if (f[B_LTU]) c = (a < b);
      else if (f[B_GEU]) c = (a >= b);
    end else if (g[2]) begin
      if (f[G_ADD]) r = a + b;
      else if (f[G_XOR]) r = a ^ b;
      else if (f[G_OR]) r = a | b;
      else if (f[G_AND]) r = a & b;
      else if (f[G_SWAP]) r = b;
      else if (f[G_MAX]) r = (sa > sb) ? a : b;
      else if (f[G_MIN]) r = (sa < sb) ? a : b;
      else if (f[G_MAXU]) r = (a > b) ? a : b;
      else if (f[G_MINU]) r = (a < b) ? a : b;
    end
    return {g, c, r};
  endfunction

  function automatic logic [26:0] flag_of(input int n);
    return 27'd1 << n;
  endfunction

  task automatic add_row(input logic [2:0] rq, input logic [26:0] f, input logic [31:0] a,
                         input logic [31:0] b, input logic [31:0] r, input logic c,
                         input logic [2:0] g);
    rows.push_back('{rq, f, a, b, r, c, g});
  endtask

  ////////////////////////////////////////////////////////////
  // Hand-written rows
  ////////////////////////////////////////////////////////////
  task automatic build_table();
    // ALU overflow and borrow edges
    add_row(R_ALU, flag_of(A_ADD), 32'h7fff_ffff, 32'h1, 32'h8000_0000, 1'b0, R_ALU);
    add_row(R_ALU, flag_of(A_SUB), 32'h0, 32'h1, 32'hffff_ffff, 1'b0, R_ALU);
    add_row(R_ALU, flag_of(A_XOR), 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0ff0_0ff0, 1'b0, R_ALU);
    add_row(R_ALU, flag_of(A_OR), 32'hf0f0_f0f0, 32'hff00_ff00, 32'hfff0_fff0, 1'b0, R_ALU);
    add_row(R_ALU, flag_of(A_AND), 32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000, 1'b0, R_ALU);
    // Shifts by 0 and 31
    add_row(R_ALU, flag_of(A_SLL), 32'h8000_0001, 32'h0, 32'h8000_0001, 1'b0, R_ALU);
    add_row(R_ALU, flag_of(A_SLL), 32'h8000_0001, 32'h1f, 32'h8000_0000, 1'b0, R_ALU);
    add_row(R_ALU, flag_of(A_SRL), 32'h8000_0001, 32'h1f, 32'h1, 1'b0, R_ALU);
    add_row(R_ALU, flag_of(A_SRA), 32'h8000_0000, 32'h4, 32'hf800_0000, 1'b0, R_ALU);
    add_row(R_ALU, flag_of(A_SRA), 32'h8000_0000, 32'h1f, 32'hffff_ffff, 1'b0, R_ALU);
    // Only op2 bits 4..0 count
    add_row(R_ALU, flag_of(A_SRA), 32'h4000_0000, 32'h21, 32'h2000_0000, 1'b0, R_ALU);
    add_row(R_ALU, flag_of(A_SLT), NEG, POS, 32'h1, 1'b0, R_ALU);
    add_row(R_ALU, flag_of(A_SLTU), NEG, POS, 32'h0, 1'b0, R_ALU);
    add_row(R_ALU, flag_of(A_LUI), 32'h1234_5678, 32'habcd_e000, 32'habcd_e000, 1'b0, R_ALU);
    // OR comes before SLL in opcode order
    add_row(R_ALU, flag_of(A_OR) | flag_of(A_SLL), 32'hf0f0_f0f0, 32'h4, 32'hf0f0_f0f4,
            1'b0, R_ALU);
    // BJP add and compares
    add_row(R_BJP, flag_of(B_ADD), 32'hffff_ffff, 32'h2, 32'h1, 1'b0, R_BJP);
    add_row(R_BJP, flag_of(B_EQ), 32'h1234, 32'h1234, 32'h0, 1'b1, R_BJP);
    add_row(R_BJP, flag_of(B_NE), NEG, POS, 32'h0, 1'b1, R_BJP);
    add_row(R_BJP, flag_of(B_LT), NEG, POS, 32'h0, 1'b1, R_BJP);
    add_row(R_BJP, flag_of(B_GE), NEG, POS, 32'h0, 1'b0, R_BJP);
    add_row(R_BJP, flag_of(B_LTU), NEG, POS, 32'h0, 1'b0, R_BJP);
    add_row(R_BJP, flag_of(B_GEU), NEG, POS, 32'h0, 1'b1, R_BJP);
    add_row(R_BJP, flag_of(B_LTU), POS, NEG, 32'h0, 1'b1, R_BJP);
    // AGU max/min on the mixed pair
    add_row(R_AGU, flag_of(G_MAX), NEG, POS, POS, 1'b0, R_AGU);
    add_row(R_AGU, flag_of(G_MIN), NEG, POS, NEG, 1'b0, R_AGU);
    add_row(R_AGU, flag_of(G_MAXU), NEG, POS, NEG, 1'b0, R_AGU);
    add_row(R_AGU, flag_of(G_MINU), NEG, POS, POS, 1'b0, R_AGU);
    add_row(R_AGU, flag_of(G_SWAP), 32'h1111_1111, 32'h2222_2222, 32'h2222_2222, 1'b0, R_AGU);
    add_row(R_AGU, flag_of(G_ADD), 32'h1000, 32'h0234, 32'h1234, 1'b0, R_AGU);
    add_row(R_AGU, flag_of(G_AND), 32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000, 1'b0, R_AGU);
    add_row(R_AGU, flag_of(G_OR), 32'hf0f0_f0f0, 32'hff00_ff00, 32'hfff0_fff0, 1'b0, R_AGU);
    add_row(R_AGU, flag_of(G_XOR), 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0ff0_0ff0, 1'b0, R_AGU);
    // Winner of several requests decides the operation
    add_row(3'b111, flag_of(A_ADD) | flag_of(B_EQ) | flag_of(G_XOR), 32'h3, 32'h3, 32'h6,
            1'b0, R_ALU);
    add_row(3'b110, flag_of(A_ADD) | flag_of(B_EQ) | flag_of(G_XOR), 32'h3, 32'h3, 32'h0,
            1'b1, R_BJP);
    // ALU granted without a flag of its own
    add_row(3'b111, flag_of(G_XOR), 32'h3, 32'h3, 32'h0, 1'b0, R_ALU);
    // Idle datapath
    add_row(3'b000, flag_of(A_ADD), 32'h3, 32'h3, 32'h0, 1'b0, 3'b000);
  endtask

  task automatic add_random_rows(input int n);
    int          w;
    int          idx;
    logic [2:0]  rq;
    logic [31:0] a;
    logic [31:0] b;
    logic [35:0] p;
    for (int k = 0; k < n; k++) begin
      // Winner 3 means no request at all
      w = $urandom_range(3, 0);
      rq = (w == 3) ? 3'b000 : 3'((3'($urandom) | 3'b001) << w);
      case (w)
        0: idx = $urandom_range(A_LUI, A_ADD);
        1: idx = $urandom_range(B_GEU, B_ADD);
        2: idx = $urandom_range(G_MINU, G_ADD);
        default: idx = $urandom_range(G_MINU, A_ADD);
      endcase
      a = $urandom;
      // Every fourth pair equal
      b = ($urandom_range(3, 0) == 0) ? a : $urandom;
      p = predict(rq, flag_of(idx), a, b);
      add_row(rq, flag_of(idx), a, b, p[31:0], p[32], p[35:33]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checks and per-test report
  ////////////////////////////////////////////////////////////
  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp, inout bit ok);
    assert (got === exp) else begin
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
      ok = 1'b0;
    end
  endtask

  task automatic tally(input string name, input bit ok);
    if (ok) passes++;
    else fails++;
    $display("%s %s", name, ok ? "passed" : "failed");
  endtask

  task automatic run_row(input int idx, input row_t r);
    bit ok;
    ok = 1'b1;
    @(posedge clk);
    req  <= r.req;
    fl   <= r.fl;
    // Expected winner gets the row operands and the others their inverse
    for (int k = 0; k < 3; k++) begin
      op_a[k] <= r.gnt[k] ? r.a : ~r.a;
      op_b[k] <= r.gnt[k] ? r.b : ~r.b;
    end
    // Sample the combinational outputs at the falling edge
    @(negedge clk);
    check_val("res", res, r.res, ok);
    check_val("cmp_res", {31'b0, cmp_res}, {31'b0, r.cmp}, ok);
    check_val("grants", {29'b0, gnt}, {29'b0, r.gnt}, ok);
    tally($sformatf("row %0d", idx), ok);
  endtask

  task automatic buf_step(input string name, input logic [1:0] ena, input logic [31:0] n0,
                          input logic [31:0] n1, input logic [31:0] e0,
                          input logic [31:0] e1);
    bit ok;
    ok = 1'b1;
    @(posedge clk);
    sbf_ena  <= ena;
    sbf_nxt0 <= n0;
    sbf_nxt1 <= n1;
    @(negedge clk);
    check_val("agu_sbf_0_r", sbf_r0, e0, ok);
    check_val("agu_sbf_1_r", sbf_r1, e1, ok);
    tally(name, ok);
  endtask

  // Watchdog
  initial begin
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run did not finish within %0d cycles", limit);
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    rst  = 1'b1;
    req  = '0;
    fl   = '0;
    op_a = '0;
    op_b = '0;
    // Pending writes during reset must not survive it
    sbf_ena  = 2'b11;
    sbf_nxt0 = 32'hffff_ffff;
    sbf_nxt1 = 32'h1234_5678;
    void'($urandom(32'he1d9b655));
    build_table();
    add_random_rows(N_RAND);
    limit = 4 * rows.size() + 50;
    repeat (8) @(posedge clk);
    rst     <= 1'b0;
    sbf_ena <= 2'b00;
    // Buffer data shows one cycle after its enable
    buf_step("buf reset", 2'b01, 32'ha5a5_0001, 32'hdead_beef, 32'h0, 32'h0);
    buf_step("buf0 load", 2'b00, 32'h1111_1111, 32'h2222_2222, 32'ha5a5_0001, 32'h0);
    buf_step("buf1 write", 2'b10, 32'h3333_3333, 32'h0bad_f00d, 32'ha5a5_0001, 32'h0);
    buf_step("buf1 load", 2'b00, 32'h4444_4444, 32'h5555_5555, 32'ha5a5_0001,
             32'h0bad_f00d);
    buf_step("buf hold", 2'b00, 32'h6666_6666, 32'h7777_7777, 32'ha5a5_0001,
             32'h0bad_f00d);
    for (int i = 0; i < rows.size(); i++) begin
      run_row(i, rows[i]);
    end
    $display("Tests %0d, passed %0d, failed %0d", passes + fails, passes, fails);
    if (fails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
